// File: all.f
delqa_reg_pkg.sv
delqa_dma_pkg.sv
delqa_regs.sv
delqa_irq.sv
delqa_tx_seq.sv
delqa_dma.sv
delqa_top.sv
delqa_props.sv
tb_delqa.sv

// File: Bender.yml
package:
  name: delqa

sources:
  - delqa_reg_pkg.sv
  - delqa_dma_pkg.sv
  - delqa_regs.sv
  - delqa_irq.sv
  - delqa_tx_seq.sv
  - delqa_dma.sv
  - delqa_top.sv
  - target: simulation
    files:
      - delqa_props.sv
      - tb_delqa.sv

// File: tb_delqa.sv
/*
 * testbench for delqa_top: clock, reset, host memory model,
 * transmit stream monitor, stimulus table with expected values
 */
module tb_delqa import delqa_reg_pkg::*, delqa_dma_pkg::*; ();

	localparam mac_t MAC       = 48'h02_11_22_33_44_55;
	localparam int   MEM_WORDS = 2048;		// acked below this word address
	localparam int   FRAME_OFS = 16;		// frame sits behind its descriptor

	typedef enum logic [1:0] {op_wr, op_rd, op_tx, op_irq} op_e;

	typedef struct packed {
		op_e                op;
		reg_addr_t          ra;
		logic [15:0]        data;		// write data, frame words on tx
		logic [9:0]         dbits;		// descriptor bits
		logic [HADDR_W-1:0] desc;		// descriptor word address
		logic [15:0]        exp;		// csr or read value, masked
		logic [15:0]        mask;
		logic               stream;		// frame words expected
	} row_t;

	logic                wb_clk   = 1'b0;
	logic                arst_n   = 1'b0;
	reg_addr_t           wb_adr   = '0;
	logic [15:0]         wb_wdat  = '0;
	logic [15:0]         wb_rdat;
	logic                wb_cyc   = 1'b0;
	logic                wb_stb   = 1'b0;
	logic                wb_we    = 1'b0;
	logic [1:0]          wb_sel   = 2'b00;
	logic                wb_ack;
	logic                irq;
	logic                iack     = 1'b0;
	logic                dma_req;
	logic                dma_gnt  = 1'b0;
	logic [HADDR_W:0]    dma_adr;
	logic [15:0]         dma_rdat = '0;
	logic [15:0]         dma_wdat;
	logic                dma_stb;
	logic                dma_we;
	logic                dma_ack  = 1'b0;
	logic [15:0]         tx_data;
	logic                tx_valid;
	logic [WCOUNT_W+1:0] tx_len;

	logic [15:0] mem [MEM_WORDS];		// host memory, word addressed
	logic [15:0] stream_q [$];		// words seen on tx_data_o
	logic [15:0] exp_q [$];
	row_t        table_q [$];
	logic [15:0] rng    = 16'd79;		// xorshift state
	int          errors = 0;

	delqa_top #(.NXM_CYCLES(16), .STATION_MAC(MAC)) u_dut (
		.wb_clk_i(wb_clk), .arst_n_i(arst_n), .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat),
		.wb_dat_o(wb_rdat), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_sel_i(wb_sel), .wb_ack_o(wb_ack), .irq_o(irq), .iack_i(iack),
		.dma_req_o(dma_req), .dma_gnt_i(dma_gnt), .dma_adr_o(dma_adr),
		.dma_dat_i(dma_rdat), .dma_dat_o(dma_wdat), .dma_stb_o(dma_stb),
		.dma_we_o(dma_we), .dma_ack_i(dma_ack), .tx_data_o(tx_data),
		.tx_valid_o(tx_valid), .tx_len_o(tx_len)
	);

	always #10 wb_clk = ~wb_clk;		// period 20

	//**************************************
	// host memory and stream monitor
	//**************************************
	always @(posedge wb_clk) begin
		dma_gnt <= dma_req;		// bus always free
		dma_ack <= 1'b0;		// one ack per word, then a gap
		if (dma_stb && !dma_ack && dma_adr[HADDR_W:1] < MEM_WORDS) begin
			dma_ack <= 1'b1;
			if (dma_we)
				mem[dma_adr[HADDR_W:1]] <= dma_wdat;
			else
				dma_rdat <= mem[dma_adr[HADDR_W:1]];
		end
	end

	always @(negedge wb_clk) begin
		if (tx_valid)
			stream_q.push_back(tx_data);	// one pulse per word
	end

	//**************************************
	// helpers
	//**************************************
	function automatic logic [15:0] next_rand(input logic [15:0] x);
		logic [15:0] y;
		y = x ^ (x << 7);
		y = y ^ (y >> 9);
		y = y ^ (y << 8);
		return y;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			abort_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	function automatic void add_row(op_e op, reg_addr_t ra, logic [15:0] data,
			logic [9:0] dbits, logic [HADDR_W-1:0] desc, logic [15:0] exp,
			logic [15:0] mask, logic stream);
		row_t r;
		r = '{op, ra, data, dbits, desc, exp, mask, stream};
		table_q.push_back(r);
	endfunction

	task automatic bus_cycle(input logic we, input reg_addr_t ra, input logic [15:0] wdata,
			output logic [15:0] rdata);
		int n;
		@(posedge wb_clk);
		wb_adr  <= ra;
		wb_wdat <= wdata;
		wb_we   <= we;
		wb_sel  <= 2'b11;
		wb_cyc  <= 1'b1;
		wb_stb  <= 1'b1;
		n = 0;
		do begin
			@(negedge wb_clk);
			n++;
		end while (!wb_ack && n < 20);
		if (!wb_ack)
			abort_run("no wishbone ack within 20 cycles");
		rdata = wb_rdat;		// registered with the reply
		@(posedge wb_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	// descriptor words 0..3, status words preset, frame from xorshift
	task automatic load_descriptor(input row_t r);
		logic [HADDR_W-1:0] fa;
		fa = r.desc + HADDR_W'(FRAME_OFS);
		exp_q.delete();
		stream_q.delete();
		if (r.desc < MEM_WORDS) begin
			mem[r.desc]     = 16'h0000;		// flag word
			mem[r.desc + 1] = {r.dbits, fa[20:15]};
			mem[r.desc + 2] = {fa[14:0], 1'b0};
			mem[r.desc + 3] = 16'h0000 - r.data;	// negative word count
			mem[r.desc + 4] = 16'hffff;
			mem[r.desc + 5] = 16'hffff;
		end
		for (int k = 0; k < r.data; k++) begin
			rng = next_rand(rng);
			if (fa + k < MEM_WORDS)
				mem[fa + k] = rng;
			exp_q.push_back(rng);
		end
	endtask

	task automatic run_transmit(input row_t r);
		logic [15:0] rd;
		int polls;
		load_descriptor(r);
		bus_cycle(1'b1, ra_tbdl_lo, {r.desc[14:0], 1'b0}, rd);
		bus_cycle(1'b1, ra_tbdl_hi, {10'h000, r.desc[20:15]}, rd);	// high byte starts
		polls = 0;
		do begin
			bus_cycle(1'b0, ra_mac5, 16'h0000, rd);		// busy in bit 15
			polls++;
		end while (rd[15] && polls < 200);
		if (rd[15])
			abort_run("transmit still busy after 200 status polls");
		bus_cycle(1'b0, ra_csr, 16'h0000, rd);
		check_value("csr", rd & r.mask, r.exp);
		check_value("tx_valid_o count", stream_q.size(), r.stream ? r.data : 0);
		if (r.stream) begin
			foreach (exp_q[k])
				check_value("tx_data_o", stream_q[k], exp_q[k]);
			check_value("tx_len_o", tx_len, 2 * r.data - r.dbits[DB_H] - r.dbits[DB_L]);
			check_value("status word 1", mem[r.desc + 4], 0);
			check_value("status word 2", mem[r.desc + 5], 0);
		end
	endtask

	task automatic serve_interrupt();
		logic [15:0] rd;
		int n;
		n = 0;
		do begin
			@(negedge wb_clk);
			n++;
		end while (!irq && n < 50);
		if (!irq)
			abort_run("irq_o did not rise after the transmit");
		@(posedge wb_clk);
		iack <= 1'b1;
		n = 0;
		do begin
			@(negedge wb_clk);
			n++;
		end while (irq && n < 10);
		if (irq)
			abort_run("irq_o still high after iack_i");
		@(posedge wb_clk);
		iack <= 1'b0;
		bus_cycle(1'b0, ra_mac5, 16'h0000, rd);
		check_value("int_req", rd[14], 0);	// pending flag in bit 14
	endtask

	//**************************************
	// stimulus table and run
	//**************************************
	function automatic void build_table();
		add_row(op_rd,  ra_csr,  16'h0000, 10'h000, 21'h0,    16'h0030, 16'h0030, 1'b0);
		add_row(op_rd,  ra_mac0, 16'h0000, 10'h000, 21'h0,    {8'h0, MAC[47:40]}, 16'h00ff, 1'b0);
		add_row(op_rd,  ra_mac1, 16'h0000, 10'h000, 21'h0,    {8'h0, MAC[39:32]}, 16'h00ff, 1'b0);
		add_row(op_rd,  ra_mac2, 16'h0000, 10'h000, 21'h0,    {8'h0, MAC[31:24]}, 16'h00ff, 1'b0);
		add_row(op_rd,  ra_mac3, 16'h0000, 10'h000, 21'h0,    {8'h0, MAC[23:16]}, 16'h00ff, 1'b0);
		add_row(op_rd,  ra_mac4, 16'h0000, 10'h000, 21'h0,    {8'h0, MAC[15:8]},  16'h00ff, 1'b0);
		add_row(op_rd,  ra_mac5, 16'h0000, 10'h000, 21'h0,    {8'h0, MAC[7:0]},   16'h00ff, 1'b0);
		add_row(op_wr,  ra_var,  16'h02a8, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_rd,  ra_var,  16'h0000, 10'h000, 21'h0,    16'h02a8, 16'h03fc, 1'b0);
		add_row(op_tx,  ra_csr,  16'd5,    10'h280, 21'h100,  16'h0080, 16'h0094, 1'b1);
		add_row(op_wr,  ra_csr,  16'h0080, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_tx,  ra_csr,  16'd3,    10'h080, 21'h140,  16'h0014, 16'h0094, 1'b0);
		add_row(op_wr,  ra_csr,  16'h0080, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_tx,  ra_csr,  16'd4,    10'h280, 21'h1000, 16'h0014, 16'h0094, 1'b0);
		add_row(op_wr,  ra_csr,  16'h00c0, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_tx,  ra_csr,  16'd7,    10'h283, 21'h180,  16'h00c0, 16'h00d4, 1'b1);
		add_row(op_irq, ra_csr,  16'h0000, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_wr,  ra_csr,  16'h00c0, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_rd,  ra_csr,  16'h0000, 10'h000, 21'h0,    16'h0040, 16'h00c0, 1'b0);
		add_row(op_tx,  ra_csr,  16'd2,    10'h280, 21'h1c0,  16'h00c0, 16'h00d4, 1'b1);
		add_row(op_wr,  ra_csr,  16'h0042, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_wr,  ra_csr,  16'h0040, 10'h000, 21'h0,    16'h0000, 16'h0000, 1'b0);
		add_row(op_rd,  ra_csr,  16'h0000, 10'h000, 21'h0,    16'h0030, 16'h00f0, 1'b0);
		add_row(op_rd,  ra_var,  16'h0000, 10'h000, 21'h0,    16'h02a8, 16'h03fc, 1'b0);
	endfunction

	initial begin
		logic [15:0] rd;
		row_t r;
		build_table();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 16'(i) ^ 16'hc3c3;		// unique per address
		repeat (3) @(posedge wb_clk);
		arst_n <= 1'b1;
		foreach (table_q[i]) begin
			r = table_q[i];
			case (r.op)
				op_wr: bus_cycle(1'b1, r.ra, r.data, rd);
				op_rd: begin
					bus_cycle(1'b0, r.ra, 16'h0000, rd);
					check_value($sformatf("wb_dat_o reg %0d", r.ra), rd & r.mask, r.exp);
				end
				op_tx:   run_transmit(r);
				default: serve_interrupt();
			endcase
		end
		repeat (2) @(posedge wb_clk);
		if (errors == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			abort_run("errors were recorded during the run");
		end
	end

	// generous bound per table row
	initial begin
		#1;
		repeat (table_q.size() * 2000) @(posedge wb_clk);
		abort_run("watchdog expired, the run did not finish in time");
	end

endmodule

// File: delqa_props.sv
/*
 * bound protocol assertions: strobe and ack qualification,
 * pending interrupt request dropped after the acknowledge
 */
module delqa_props #(
	parameter bit IRQ_CHK = 1'b0		// register file instance sees the request
) (
	input logic wb_clk_i,
	input logic arst_n_i,
	input logic cond_i,		// ack or dma strobe
	input logic qual_i,		// its cycle and strobe, or grant
	input logic clr_i,		// iack seen by the irq FSM
	input logic flag_i		// pending request
);

	// wishbone ack only inside a strobed cycle, dma strobe only under grant
	a_qualified: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		cond_i |-> qual_i) else $error("cond_i high without its qualifier");

	a_known: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		!$isunknown(cond_i)) else $error("cond_i unknown after reset");

	// irq_o falls on the clr edge, the request must follow
	if (IRQ_CHK) begin : g_irq
		a_req_drops: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
			clr_i |=> !flag_i) else $error("interrupt request still set after iack");
	end

endmodule

bind delqa_regs delqa_props #(.IRQ_CHK(1'b1)) u_regs_props (
	.wb_clk_i, .arst_n_i, .cond_i(wb_ack_o), .qual_i(wb_cyc_i & wb_stb_i),
	.clr_i(irq_clr_i), .flag_i(int_req_o)
);

bind delqa_dma delqa_props u_dma_props (
	.wb_clk_i, .arst_n_i, .cond_i(dma_stb_o), .qual_i(dma_gnt_i),
	.clr_i(1'b0), .flag_i(1'b0)
);

// File: delqa_top.sv
/*
 * controller top level: register file, interrupt FSM,
 * transmit sequencer and DMA master
 */
module delqa_top import delqa_reg_pkg::*, delqa_dma_pkg::*; #(
	parameter int   NXM_CYCLES  = 64,
	parameter mac_t STATION_MAC = 48'h02_00_00_a1_b2_c3
) (
	input  logic                wb_clk_i,
	input  logic                arst_n_i,
	input  reg_addr_t           wb_adr_i,
	input  logic [WORD_W-1:0]   wb_dat_i,
	output logic [WORD_W-1:0]   wb_dat_o,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [1:0]          wb_sel_i,
	output logic                wb_ack_o,
	output logic                irq_o,
	input  logic                iack_i,
	output logic                dma_req_o,
	input  logic                dma_gnt_i,
	output logic [HADDR_W:0]    dma_adr_o,
	input  logic [WORD_W-1:0]   dma_dat_i,
	output logic [WORD_W-1:0]   dma_dat_o,
	output logic                dma_stb_o,
	output logic                dma_we_o,
	input  logic                dma_ack_i,
	output logic [WORD_W-1:0]   tx_data_o,
	output logic                tx_valid_o,
	output logic [WCOUNT_W+1:0] tx_len_o
);

	logic               tx_start;
	logic [HADDR_W-1:0] tbdl_addr;
	logic               ie;
	logic               int_req;
	logic               soft_rst;		// resets all but the VAR
	logic               irq_clr;
	logic               tx_busy;
	logic               tx_done;
	logic               tx_err;
	logic               nxm_err;
	dma_cmd_t           dma_cmd;
	logic               dma_go;
	logic               dma_done;
	logic               nxm;
	logic [WORD_W-1:0]  rd_word;
	logic               rd_valid;
	logic [WORD_W-1:0]  wr_word;

	delqa_regs #(.STATION_MAC(STATION_MAC)) u_regs (
		.wb_clk_i, .arst_n_i, .wb_adr_i, .wb_dat_i, .wb_dat_o,
		.wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_ack_o,
		.tx_start_o(tx_start), .tbdl_addr_o(tbdl_addr), .ie_o(ie),
		.int_req_o(int_req), .soft_rst_o(soft_rst), .irq_clr_i(irq_clr),
		.tx_busy_i(tx_busy), .tx_done_i(tx_done), .tx_err_i(tx_err),
		.nxm_err_i(nxm_err)
	);

	delqa_irq u_irq (
		.wb_clk_i, .arst_n_i, .soft_rst_i(soft_rst), .ie_i(ie),
		.int_req_i(int_req), .iack_i, .irq_o, .irq_clr_o(irq_clr)
	);

	delqa_tx_seq u_tx_seq (
		.wb_clk_i, .arst_n_i, .soft_rst_i(soft_rst),
		.tx_start_i(tx_start), .tbdl_addr_i(tbdl_addr),
		.tx_busy_o(tx_busy), .tx_done_o(tx_done), .tx_err_o(tx_err),
		.nxm_err_o(nxm_err), .dma_cmd_o(dma_cmd), .dma_go_o(dma_go),
		.dma_done_i(dma_done), .nxm_i(nxm), .rd_word_i(rd_word),
		.rd_valid_i(rd_valid), .wr_word_o(wr_word),
		.tx_data_o, .tx_valid_o, .tx_len_o
	);

	delqa_dma #(.NXM_CYCLES(NXM_CYCLES)) u_dma (
		.wb_clk_i, .arst_n_i, .soft_rst_i(soft_rst),
		.cmd_i(dma_cmd), .go_i(dma_go), .done_o(dma_done), .nxm_o(nxm),
		.rd_word_o(rd_word), .rd_valid_o(rd_valid), .wr_word_i(wr_word),
		.dma_req_o, .dma_gnt_i, .dma_adr_o, .dma_dat_i, .dma_dat_o,
		.dma_stb_o, .dma_we_o, .dma_ack_i
	);

endmodule

// File: delqa_dma.sv
/*
 * host memory DMA master: bus request, per-word strobe,
 * word counter and nonexistent-memory timeout
 */
module delqa_dma import delqa_reg_pkg::*, delqa_dma_pkg::*; #(
	parameter int NXM_CYCLES = 64
) (
	input  logic               wb_clk_i,
	input  logic               arst_n_i,
	input  logic               soft_rst_i,
	input  dma_cmd_t           cmd_i,
	input  logic               go_i,
	output logic               done_o,
	output logic               nxm_o,
	output logic [WORD_W-1:0]  rd_word_o,
	output logic               rd_valid_o,
	input  logic [WORD_W-1:0]  wr_word_i,
	output logic               dma_req_o,
	input  logic               dma_gnt_i,
	output logic [HADDR_W:0]   dma_adr_o,
	input  logic [WORD_W-1:0]  dma_dat_i,
	output logic [WORD_W-1:0]  dma_dat_o,
	output logic               dma_stb_o,
	output logic               dma_we_o,
	input  logic               dma_ack_i
);

	localparam int TMO_W = $clog2(NXM_CYCLES + 1);

	logic [HADDR_W-1:0]  addr_q;
	logic [WCOUNT_W-1:0] wcnt_q;		// counts up to zero
	logic [TMO_W-1:0]    tmo_q;
	logic                we_q;
	logic                last_word;
	logic                timeout;

	assign last_word = (wcnt_q == {WCOUNT_W{1'b1}});	// -1, this ack ends it
	assign timeout   = (tmo_q == TMO_W'(NXM_CYCLES - 1));
	assign dma_adr_o = {addr_q, 1'b0};			// byte address
	assign dma_dat_o = wr_word_i;
	assign dma_we_o  = dma_stb_o & we_q;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dma_req_o  <= 1'b0;
			dma_stb_o  <= 1'b0;
			done_o     <= 1'b0;
			nxm_o      <= 1'b0;
			rd_valid_o <= 1'b0;
			tmo_q      <= '0;
		end else if (soft_rst_i) begin
			dma_req_o  <= 1'b0;
			dma_stb_o  <= 1'b0;
			done_o     <= 1'b0;
			nxm_o      <= 1'b0;
			rd_valid_o <= 1'b0;
			tmo_q      <= '0;
		end else begin
			done_o     <= 1'b0;
			rd_valid_o <= 1'b0;
			if (go_i && !dma_req_o) begin
				dma_req_o <= 1'b1;		// ask for the bus
				nxm_o     <= 1'b0;
				tmo_q     <= '0;
			end else if (dma_req_o && !dma_stb_o) begin
				dma_stb_o <= dma_gnt_i;		// strobe once granted
			end else if (dma_stb_o) begin
				if (dma_ack_i) begin
					rd_valid_o <= ~we_q;
					tmo_q      <= '0;
					if (last_word) begin
						dma_req_o <= 1'b0;
						dma_stb_o <= 1'b0;
						done_o    <= 1'b1;
					end
				end else if (timeout) begin
					dma_req_o <= 1'b0;	// nobody answers, give up
					dma_stb_o <= 1'b0;
					done_o    <= 1'b1;
					nxm_o     <= 1'b1;
				end else begin
					tmo_q <= tmo_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (go_i && !dma_req_o) begin
			addr_q <= cmd_i.addr;
			wcnt_q <= cmd_i.wcount;
			we_q   <= cmd_i.we;
		end else if (dma_stb_o && dma_ack_i) begin
			addr_q    <= addr_q + 1'b1;		// next word
			wcnt_q    <= wcnt_q + 1'b1;
			rd_word_o <= dma_dat_i;
		end
	end

endmodule

// File: delqa_tx_seq.sv
/*
 * transmit sequencer: descriptor fetch, V/E check, frame read
 * to the word stream, status write-back and completion flags
 */
module delqa_tx_seq import delqa_reg_pkg::*, delqa_dma_pkg::*; (
	input  logic                wb_clk_i,
	input  logic                arst_n_i,
	input  logic                soft_rst_i,
	input  logic                tx_start_i,
	input  logic [HADDR_W-1:0]  tbdl_addr_i,
	output logic                tx_busy_o,
	output logic                tx_done_o,
	output logic                tx_err_o,
	output logic                nxm_err_o,
	output dma_cmd_t            dma_cmd_o,
	output logic                dma_go_o,
	input  logic                dma_done_i,
	input  logic                nxm_i,
	input  logic [WORD_W-1:0]   rd_word_i,
	input  logic                rd_valid_i,
	output logic [WORD_W-1:0]   wr_word_o,
	output logic [WORD_W-1:0]   tx_data_o,
	output logic                tx_valid_o,
	output logic [WCOUNT_W+1:0] tx_len_o
);

	typedef enum logic [2:0] {s_idle, s_desc, s_check, s_frame, s_stat} seq_state_e;

	seq_state_e                    state_q;
	tx_desc_t                      desc_q;
	logic [HADDR_W-1:0]            base_q;		// descriptor address
	logic [$clog2(DESC_WORDS)-1:0] widx_q;
	logic [WCOUNT_W:0]             nwords;
	logic                          desc_ok;

	assign nwords    = {1'b0, ~desc_q.wcount} + 1'b1;	// negate, 0 gives 1024
	assign desc_ok   = desc_q.bits[DB_V] & desc_q.bits[DB_E];
	assign wr_word_o = '0;		// tx status words: no errors, no collisions

	//**************************************
	// control FSM
	//**************************************
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= s_idle;
			tx_busy_o  <= 1'b0;
			tx_done_o  <= 1'b0;
			tx_err_o   <= 1'b0;
			nxm_err_o  <= 1'b0;
			dma_go_o   <= 1'b0;
			tx_valid_o <= 1'b0;
		end else if (soft_rst_i) begin
			state_q    <= s_idle;
			tx_busy_o  <= 1'b0;
			tx_done_o  <= 1'b0;
			tx_err_o   <= 1'b0;
			nxm_err_o  <= 1'b0;
			dma_go_o   <= 1'b0;
			tx_valid_o <= 1'b0;
		end else begin
			tx_done_o  <= 1'b0;
			dma_go_o   <= 1'b0;
			tx_valid_o <= (state_q == s_frame) & rd_valid_i;	// one pulse per frame word
			case (state_q)
				s_idle: if (tx_start_i) begin
					tx_busy_o <= 1'b1;
					tx_err_o  <= 1'b0;
					nxm_err_o <= 1'b0;
					dma_go_o  <= 1'b1;		// fetch descriptor
					state_q   <= s_desc;
				end
				s_check: begin
					if (desc_ok) begin
						dma_go_o <= 1'b1;	// read frame
						state_q  <= s_frame;
					end else begin
						tx_err_o  <= 1'b1;	// no V or E, skip frame and status
						tx_done_o <= 1'b1;
						tx_busy_o <= 1'b0;
						state_q   <= s_idle;
					end
				end
				s_desc, s_frame, s_stat: if (dma_done_i) begin
					if (nxm_i || state_q == s_stat) begin
						tx_err_o  <= nxm_i;	// nxm aborts any phase
						nxm_err_o <= nxm_i;
						tx_done_o <= 1'b1;
						tx_busy_o <= 1'b0;
						state_q   <= s_idle;
					end else begin
						dma_go_o <= (state_q == s_frame);	// status write next
						state_q  <= (state_q == s_desc) ? s_check : s_stat;
					end
				end
				default: state_q <= s_idle;
			endcase
		end
	end

	//**************************************
	// descriptor capture, DMA commands
	//**************************************
	always_ff @(posedge wb_clk_i) begin
		if (state_q == s_idle && tx_start_i) begin
			base_q    <= tbdl_addr_i;
			widx_q    <= '0;
			dma_cmd_o <= '{we: 1'b0, addr: tbdl_addr_i, wcount: WCOUNT_W'(-DESC_WORDS)};
		end
		if (state_q == s_desc && rd_valid_i) begin
			widx_q <= widx_q + 1'b1;
			case (widx_q)
				2'd1: begin
					desc_q.bits                <= rd_word_i[15:6];
					desc_q.addr[HADDR_W-1:15] <= rd_word_i[5:0];	// address 21:16
				end
				2'd2: desc_q.addr[14:0] <= rd_word_i[15:1];
				2'd3: desc_q.wcount     <= rd_word_i[WCOUNT_W-1:0];
				default: ;		// flag word, unused on transmit
			endcase
		end
		if (state_q == s_check && desc_ok) begin
			dma_cmd_o <= '{we: 1'b0, addr: desc_q.addr, wcount: desc_q.wcount};
			tx_len_o  <= {nwords, 1'b0} - desc_q.bits[DB_H] - desc_q.bits[DB_L];
		end
		if (state_q == s_frame && dma_done_i)
			dma_cmd_o <= '{we: 1'b1, addr: base_q + HADDR_W'(STW_OFFSET),
				wcount: WCOUNT_W'(-2)};		// two status words
		if (state_q == s_frame && rd_valid_i)
			tx_data_o <= rd_word_i;
	end

endmodule

// File: delqa_irq.sv
/*
 * vectored interrupt FSM: idle, request, wait for iack release
 */
module delqa_irq (
	input  logic wb_clk_i,
	input  logic arst_n_i,
	input  logic soft_rst_i,
	input  logic ie_i,
	input  logic int_req_i,
	input  logic iack_i,
	output logic irq_o,
	output logic irq_clr_o
);

	typedef enum logic [1:0] {s_idle, s_req, s_wait} irq_state_e;

	irq_state_e state_q;

	// clears the pending flag on the same edge that drops irq_o
	assign irq_clr_o = (state_q == s_req) & ie_i & iack_i;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= s_idle;
			irq_o   <= 1'b0;
		end else if (soft_rst_i) begin
			state_q <= s_idle;
			irq_o   <= 1'b0;
		end else begin
			case (state_q)
				s_idle: begin
					irq_o <= ie_i & int_req_i;		// also drops a stale request
					if (ie_i && int_req_i)
						state_q <= s_req;
				end
				s_req: begin
					if (!ie_i) begin
						state_q <= s_idle;		// irq_o falls next clock
					end else if (iack_i) begin
						irq_o   <= 1'b0;
						state_q <= s_wait;
					end
				end
				s_wait: if (!iack_i) state_q <= s_idle;	// wait for iack release
				default: state_q <= s_idle;
			endcase
		end
	end

endmodule

// File: delqa_regs.sv
/*
 * wishbone register file: CSR, VAR, BDL address registers
 * station address readback, ack generation
 * transmit start and soft reset pulses, pending interrupt flag
 */
module delqa_regs import delqa_reg_pkg::*, delqa_dma_pkg::*; #(
	parameter mac_t STATION_MAC = 48'h02_00_00_00_00_01
) (
	input  logic               wb_clk_i,
	input  logic               arst_n_i,
	input  reg_addr_t          wb_adr_i,
	input  logic [WORD_W-1:0]  wb_dat_i,
	output logic [WORD_W-1:0]  wb_dat_o,
	input  logic               wb_cyc_i,
	input  logic               wb_stb_i,
	input  logic               wb_we_i,
	input  logic [1:0]         wb_sel_i,
	output logic               wb_ack_o,
	output logic               tx_start_o,
	output logic [HADDR_W-1:0] tbdl_addr_o,
	output logic               ie_o,
	output logic               int_req_o,
	output logic               soft_rst_o,
	input  logic               irq_clr_i,
	input  logic               tx_busy_i,
	input  logic               tx_done_i,
	input  logic               tx_err_i,
	input  logic               nxm_err_i
);

	csr_t        csr_q;
	var_t        var_q;
	logic [15:1] rbdl_lo_q;
	logic [5:0]  rbdl_hi_q;
	logic [15:1] tbdl_lo_q;
	logic [5:0]  tbdl_hi_q;
	logic        reply_q;
	logic        int_req_q;
	logic        nxm_seen_q;
	logic        tx_start_q;
	logic        soft_rst_q;
	logic        bus_req;
	logic        wr_lo;
	logic        wr_hi;
	logic        busy;
	logic [7:0]  mac_byte;
	logic [7:0]  stat_byte;

	//**************************************
	// bus handshake
	//**************************************
	assign bus_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;	// first cycle of a request
	assign wr_lo    = bus_req & wb_we_i & wb_sel_i[0];
	assign wr_hi    = bus_req & wb_we_i & wb_sel_i[1];
	assign busy     = tx_busy_i | tx_start_q;		// covers the start cycle too
	assign wb_ack_o = reply_q & wb_stb_i;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			reply_q <= 1'b0;
		end else begin
			reply_q <= bus_req;		// ack one cycle after strobe
		end
	end

	//**************************************
	// read path
	//**************************************
	always_comb begin
		case (wb_adr_i)
			ra_mac0: mac_byte = STATION_MAC[47:40];
			ra_mac1: mac_byte = STATION_MAC[39:32];
			ra_mac2: mac_byte = STATION_MAC[31:24];
			ra_mac3: mac_byte = STATION_MAC[23:16];
			ra_mac4: mac_byte = STATION_MAC[15:8];
			ra_mac5: mac_byte = STATION_MAC[7:0];
			default: mac_byte = 8'h00;
		endcase
	end

	assign stat_byte = {tx_busy_i, int_req_q, nxm_seen_q, 5'b0};	// status in top byte

	always_ff @(posedge wb_clk_i) begin
		if (bus_req && !wb_we_i) begin
			case (wb_adr_i)
				ra_var:  wb_dat_o <= var_q;
				ra_csr:  wb_dat_o <= csr_q;
				ra_mac5: wb_dat_o <= {stat_byte, mac_byte};
				default: wb_dat_o <= {8'h00, mac_byte};
			endcase
		end
	end

	//**************************************
	// BDL address registers
	//**************************************
	always_ff @(posedge wb_clk_i) begin
		if (!busy) begin
			if (wr_lo) begin
				case (wb_adr_i)
					ra_rbdl_lo: rbdl_lo_q[7:1] <= wb_dat_i[7:1];	// bit 0 ignored, word aligned
					ra_rbdl_hi: rbdl_hi_q      <= wb_dat_i[5:0];
					ra_tbdl_lo: tbdl_lo_q[7:1] <= wb_dat_i[7:1];
					ra_tbdl_hi: tbdl_hi_q      <= wb_dat_i[5:0];
					default: ;
				endcase
			end
			if (wr_hi) begin
				case (wb_adr_i)
					ra_rbdl_lo: rbdl_lo_q[15:8] <= wb_dat_i[15:8];
					ra_tbdl_lo: tbdl_lo_q[15:8] <= wb_dat_i[15:8];
					default: ;
				endcase
			end
		end
	end

	assign tbdl_addr_o = {tbdl_hi_q, tbdl_lo_q};

	// vector register, writable at any time, survives soft reset
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			var_q <= '0;
		end else begin
			if (wr_lo && wb_adr_i == ra_var) begin
				var_q.id      <= wb_dat_i[0];
				var_q.iv[5:0] <= wb_dat_i[7:2];
			end
			if (wr_hi && wb_adr_i == ra_var) begin
				var_q.iv[7:6] <= wb_dat_i[9:8];
				var_q.rs      <= wb_dat_i[13];
				var_q.ms      <= wb_dat_i[15];
			end
		end
	end

	//**************************************
	// CSR, start and soft reset pulses
	//**************************************
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			csr_q      <= CSR_RST;
			int_req_q  <= 1'b0;
			nxm_seen_q <= 1'b0;
			tx_start_q <= 1'b0;
			soft_rst_q <= 1'b0;
		end else if (soft_rst_q) begin
			csr_q      <= CSR_RST;
			int_req_q  <= 1'b0;
			nxm_seen_q <= 1'b0;
			tx_start_q <= 1'b0;
			soft_rst_q <= 1'b0;
		end else begin
			tx_start_q <= wr_hi & (wb_adr_i == ra_tbdl_hi) & ~busy;	// high byte starts tx
			soft_rst_q <= wr_lo & (wb_adr_i == ra_csr) & csr_q.sr & ~wb_dat_i[1];	// sr 1 -> 0
			if (wr_lo && wb_adr_i == ra_csr) begin
				csr_q.sr <= wb_dat_i[1];		// accepted even while busy
				if (!busy) begin
					csr_q.ie <= wb_dat_i[6];
					csr_q.bd <= wb_dat_i[3];
					csr_q.re <= wb_dat_i[0];
					if (wb_dat_i[7]) begin	// w1 clears xi and ni
						csr_q.xi <= 1'b0;
						csr_q.ni <= 1'b0;
					end
				end
			end
			if (wr_hi && wb_adr_i == ra_csr && !busy) begin
				csr_q.il <= wb_dat_i[8];
				csr_q.el <= wb_dat_i[9];
				csr_q.se <= wb_dat_i[10];
				if (wb_dat_i[15])
					csr_q.ri <= 1'b0;
			end
			if (tx_start_q) begin
				csr_q.xl   <= 1'b0;		// list now valid
				nxm_seen_q <= 1'b0;
			end
			if (irq_clr_i)
				int_req_q <= 1'b0;		// vector taken
			if (tx_done_i) begin
				nxm_seen_q <= nxm_err_i;
				if (tx_err_i) begin
					csr_q.ni <= 1'b1;
					csr_q.xl <= 1'b1;	// list invalid again
				end else begin
					csr_q.xi  <= 1'b1;
					int_req_q <= 1'b1;
				end
			end
		end
	end

	assign ie_o       = csr_q.ie;
	assign int_req_o  = int_req_q;
	assign tx_start_o = tx_start_q;
	assign soft_rst_o = soft_rst_q;

endmodule

// File: delqa_dma_pkg.sv
/*
 * host DMA widths and command struct
 * buffer descriptor layout and bit positions
 */
package delqa_dma_pkg;

	localparam int HADDR_W  = 21;		// word address, byte address bits 21:1
	localparam int WCOUNT_W = 10;

	typedef struct packed {
		logic                we;		// 1 = write to host memory
		logic [HADDR_W-1:0]  addr;		// first word
		logic [WCOUNT_W-1:0] wcount;	// negative count, 0 = 1024 words
	} dma_cmd_t;

	// descriptor as captured from host memory
	//   word 1  bits[15:6] descriptor bits, [5:0] address 21:16
	//   word 2  address 15:1
	//   word 3  negative word count
	typedef struct packed {
		logic [9:0]          bits;
		logic [HADDR_W-1:0]  addr;
		logic [WCOUNT_W-1:0] wcount;
	} tx_desc_t;

	localparam int DB_V = 9;		// valid
	localparam int DB_E = 7;		// end of message
	localparam int DB_H = 1;		// odd start byte
	localparam int DB_L = 0;		// odd end byte

	localparam int STW_OFFSET = 4;		// status words follow the four descriptor words
	localparam int DESC_WORDS = 4;

endpackage

// File: delqa_reg_pkg.sv
/*
 * register map indices and bus widths
 * CSR and VAR bit layouts, CSR reset value
 */
package delqa_reg_pkg;

	localparam int WORD_W = 16;			// q-bus data width

	typedef logic [2:0]  reg_addr_t;		// word index within the block
	typedef logic [47:0] mac_t;			// first byte on the wire in [47:40]

	// read side of the map
	localparam reg_addr_t ra_mac0    = 3'd0;
	localparam reg_addr_t ra_mac1    = 3'd1;
	localparam reg_addr_t ra_mac2    = 3'd2;
	localparam reg_addr_t ra_mac3    = 3'd3;
	localparam reg_addr_t ra_mac4    = 3'd4;
	localparam reg_addr_t ra_mac5    = 3'd5;
	// write side shares indices 2..5
	localparam reg_addr_t ra_rbdl_lo = 3'd2;
	localparam reg_addr_t ra_rbdl_hi = 3'd3;
	localparam reg_addr_t ra_tbdl_lo = 3'd4;
	localparam reg_addr_t ra_tbdl_hi = 3'd5;
	localparam reg_addr_t ra_var     = 3'd6;	// both directions
	localparam reg_addr_t ra_csr     = 3'd7;	// both directions

	typedef struct packed {
		logic ri;	// 15 receive irq, w1 clears
		logic pe;	// 14 memory parity error, reads 0
		logic ca;	// 13 carrier
		logic ok;	// 12 transceiver power ok
		logic rsv;	// 11
		logic se;	// 10 sanity timer enable
		logic el;	// 09 external loopback
		logic il;	// 08 internal loopback, active low
		logic xi;	// 07 transmit irq, w1 clears
		logic ie;	// 06 interrupt enable
		logic rl;	// 05 receive list invalid
		logic xl;	// 04 transmit list invalid
		logic bd;	// 03 boot/diag rom load
		logic ni;	// 02 nxm or list error
		logic sr;	// 01 soft reset, 1 then 0
		logic re;	// 00 receiver enable
	} csr_t;

	localparam csr_t CSR_RST = '{ok: 1'b1, rl: 1'b1, xl: 1'b1, default: 1'b0};

	typedef struct packed {
		logic       ms;		// mode select
		logic       os;		// option switch
		logic       rs;		// request self-test
		logic       s3;		// self-test status, 0 = passed
		logic       s2;
		logic       s1;
		logic [7:0] iv;		// interrupt vector, bits 9:2
		logic       rsv;
		logic       id;		// identity test bit
	} var_t;

endpackage
